/* logic/rv_exec_pkg.sv */
// Execute path package: instruction views, ALU control, branch flags and stage items
`default_nettype none

package rv_exec_pkg;

  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // same 32-bit word, read as R-type or I-type
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // one-hot operation enables, is_word in bit 0
  typedef struct packed {
    logic op_add;
    logic op_sub;
    logic op_slt;
    logic op_sltu;
    logic op_xor;
    logic op_or;
    logic op_and;
    logic op_sll;
    logic op_srl;
    logic op_sra;
    logic op_andn;
    logic op_wri;
    logic is_word;
  } alu_ctrl_t;

  typedef struct packed {
    logic eq;
    logic ne;
    logic lt;
    logic ge;
    logic ltu;
    logic geu;
  } bj_flags_t;

  typedef struct packed {
    logic none;
    logic beq;
    logic bne;
    logic blt;
    logic bge;
    logic bltu;
    logic bgeu;
    logic jal;
    logic jalr;
  } br_kind_t;

  typedef struct packed {
    logic        valid;
    alu_ctrl_t   ctrl;
    logic [63:0] op1;
    logic [63:0] op2;
    logic [63:0] rs1_val;
    logic [63:0] imm;
    logic [63:0] pc;
    logic [4:0]  rd;
    logic        wen;
    br_kind_t    br;
  } dec_item_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic        wen;
    logic [63:0] data;
  } wb_t;

  typedef struct packed {
    logic        taken;
    logic [63:0] target;
  } redirect_t;

endpackage

`default_nettype wire

/* logic/rv_decode.sv */
// Decode stage: classifies the instruction, builds ALU control and operands, one cycle
`timescale 1ns/1ps
`default_nettype none

module rv_decode
  import rv_exec_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        in_valid,
  input  instr_u      instr,
  input  logic [63:0] pc,
  input  logic [63:0] rs1_data,
  input  logic [63:0] rs2_data,
  output dec_item_t   dec_q
);

  logic [31:0] raw;
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic        reg_form;
  logic        alt;
  logic        word_ok;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] imm_b;
  logic [63:0] imm_j;
  alu_ctrl_t   arith;
  dec_item_t   d;
  logic        valid_q;
  logic        wen_q;
  alu_ctrl_t   ctrl_q;
  br_kind_t    br_q;
  logic [63:0] op1_q;
  logic [63:0] op2_q;
  logic [63:0] rs1_q;
  logic [63:0] imm_q;
  logic [63:0] pc_q;
  logic [4:0]  rd_q;

  assign raw      = instr;
  assign opc      = instr.r.opcode;
  assign f3       = instr.r.funct3;
  assign reg_form = (opc == OPC_OP) || (opc == OPC_OP_32);
  // funct7[5] and imm12[10] are the same bit, picked by format
  assign alt      = reg_form ? instr.r.funct7[5] : instr.i.imm12[10];
  assign word_ok  = (f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b101);

  assign imm_i = {{52{instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_u = {{32{raw[31]}}, raw[31:12], 12'h000};
  assign imm_b = {{51{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
  assign imm_j = {{43{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};

  always_comb begin
    arith         = '0;
    arith.is_word = (opc == OPC_OP_32) || (opc == OPC_OP_IMM_32);
    case (f3)
      3'b000:  if (reg_form && alt) arith.op_sub = 1'b1; else arith.op_add = 1'b1;
      3'b001:  arith.op_sll = 1'b1;
      3'b010:  arith.op_slt = 1'b1;
      3'b011:  arith.op_sltu = 1'b1;
      3'b100:  arith.op_xor = 1'b1;
      3'b101:  if (alt) arith.op_sra = 1'b1; else arith.op_srl = 1'b1;
      3'b110:  arith.op_or = 1'b1;
      default: if (reg_form && alt) arith.op_andn = 1'b1; else arith.op_and = 1'b1;
    endcase
  end

  always_comb begin
    d         = '0;
    d.valid   = in_valid;
    d.op1     = rs1_data;
    d.op2     = rs2_data;
    d.rs1_val = rs1_data;
    d.imm     = imm_i;
    d.pc      = pc;
    d.rd      = instr.r.rd;
    d.br.none = 1'b1;
    case (opc)
      OPC_OP, OPC_OP_IMM: begin
        d.ctrl = arith;
        d.wen  = 1'b1;
      end
      OPC_OP_32, OPC_OP_IMM_32: begin
        d.ctrl = word_ok ? arith : '0;
        d.wen  = word_ok;
      end
      OPC_LUI: begin
        d.ctrl.op_wri = 1'b1;
        d.op1         = imm_u;
        d.imm         = imm_u;
        d.wen         = 1'b1;
      end
      OPC_AUIPC: begin
        d.ctrl.op_add = 1'b1;
        d.op1         = pc;
        d.imm         = imm_u;
        d.wen         = 1'b1;
      end
      OPC_BRANCH: begin
        d.ctrl.op_sub = 1'b1;
        d.imm         = imm_b;
        d.br.beq      = (f3 == 3'b000);
        d.br.bne      = (f3 == 3'b001);
        d.br.blt      = (f3 == 3'b100);
        d.br.bge      = (f3 == 3'b101);
        d.br.bltu     = (f3 == 3'b110);
        d.br.bgeu     = (f3 == 3'b111);
        // funct3 010 and 011 are not branches
        d.br.none     = (f3 == 3'b010) || (f3 == 3'b011);
      end
      OPC_JAL, OPC_JALR: begin
        // link value pc + 4 comes out of the ALU
        d.ctrl.op_add = 1'b1;
        d.op1         = pc;
        d.imm         = (opc == OPC_JAL) ? imm_j : imm_i;
        d.wen         = 1'b1;
        d.br.none     = 1'b0;
        d.br.jal      = (opc == OPC_JAL);
        d.br.jalr     = (opc == OPC_JALR);
      end
      default: ;
    endcase
    // immediate forms take imm as the second operand
    if (opc == OPC_OP_IMM || opc == OPC_OP_IMM_32) d.op2 = imm_i;
    if (opc == OPC_AUIPC) d.op2 = imm_u;
    if (opc == OPC_JAL || opc == OPC_JALR) d.op2 = 64'd4;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      wen_q   <= 1'b0;
      ctrl_q  <= '0;
      br_q    <= '{none: 1'b1, default: 1'b0};
    end else begin
      valid_q <= d.valid;
      wen_q   <= d.wen;
      ctrl_q  <= d.ctrl;
      br_q    <= d.br;
    end
  end

  always_ff @(posedge clk) begin
    op1_q <= d.op1;
    op2_q <= d.op2;
    rs1_q <= d.rs1_val;
    imm_q <= d.imm;
    pc_q  <= d.pc;
    rd_q  <= d.rd;
  end

  assign dec_q = '{valid: valid_q, ctrl: ctrl_q, op1: op1_q, op2: op2_q, rs1_val: rs1_q,
                   imm: imm_q, pc: pc_q, rd: rd_q, wen: wen_q, br: br_q};

  // bit 0 of ctrl is is_word, the rest are the operation enables
  a_ctrl_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    dec_q.valid |-> $onehot0(dec_q.ctrl[12:1]))
    else $error("decode: more than one ALU enable set");

endmodule

`default_nettype wire

/* logic/rv_alu.sv */
// Execute ALU: 64-bit integer operations on one shifter and one adder, plus branch flags
`timescale 1ns/1ps
`default_nettype none

module rv_alu
  import rv_exec_pkg::*;
(
  input  alu_ctrl_t   ctrl,
  input  logic [63:0] op1,
  input  logic [63:0] op2,
  output logic [63:0] res,
  output bj_flags_t   flags
);

  function automatic logic [63:0] bit_rev(input logic [63:0] v);
    logic [63:0] r;
    for (int k = 0; k < 64; k++) begin
      r[k] = v[63-k];
    end
    return r;
  endfunction

  logic        op_shift;
  logic        op_right;
  logic [63:0] sh_src;
  logic [63:0] sh_in;
  logic [5:0]  sh_amt;
  logic [63:0] sh_out;
  logic [63:0] srl_res;
  logic [63:0] sra_mask;
  logic [63:0] sra_fill;
  logic [63:0] sra_res;
  logic        sub_mode;
  logic        ext;
  logic [64:0] add_a;
  logic [64:0] add_b;
  logic [64:0] sum;
  logic        sign_diff;
  logic        lt;
  logic        ltu;
  logic        eq;
  logic [63:0] xor_res;
  logic [63:0] raw_res;

  assign op_shift = ctrl.op_sll | ctrl.op_srl | ctrl.op_sra;
  assign op_right = ctrl.op_srl | ctrl.op_sra;

  // word shifts only see the low half of op1
  assign sh_src = ctrl.is_word ? {32'h0, op1[31:0]} : op1;
  // right shifts run through the left shifter on bit-reversed data
  assign sh_in  = {64{op_shift}} & (op_right ? bit_rev(sh_src) : sh_src);
  assign sh_amt = {6{op_shift}} & (ctrl.is_word ? {1'b0, op2[4:0]} : op2[5:0]);
  assign sh_out = sh_in << sh_amt;

  assign srl_res  = bit_rev(sh_out);
  // mask keeps the shifted bits, the rest gets the sign
  assign sra_mask = (ctrl.is_word ? 64'h0000_0000_ffff_ffff : {64{1'b1}}) >> sh_amt;
  assign sra_fill = ctrl.is_word ? {32'h0, {32{op1[31]}}} : {64{op1[63]}};
  assign sra_res  = (srl_res & sra_mask) | (sra_fill & ~sra_mask);

  // the adder subtracts for anything but add, so its carry carries the compare
  assign sub_mode = ~ctrl.op_add;
  // sltu compares zero-extended operands
  assign ext      = ~ctrl.op_sltu;
  assign add_a    = {ext & op1[63], op1};
  assign add_b    = {ext & op2[63], op2};
  assign sum      = add_a + (sub_mode ? ~add_b : add_b) + {64'h0, sub_mode};

  // carry gives one compare, the other follows from the operand signs
  assign sign_diff = op1[63] ^ op2[63];
  assign lt        = ext ? sum[64] : (sign_diff ? op1[63] : sum[64]);
  assign ltu       = ext ? (sign_diff ? op2[63] : sum[64]) : sum[64];

  assign xor_res = op1 ^ op2;
  assign eq      = ~|xor_res;

  assign raw_res = ({64{ctrl.op_add | ctrl.op_sub}} & sum[63:0])
                 | ({64{ctrl.op_slt}}  & {63'h0, lt})
                 | ({64{ctrl.op_sltu}} & {63'h0, ltu})
                 | ({64{ctrl.op_xor}}  & xor_res)
                 | ({64{ctrl.op_or}}   & (op1 | op2))
                 | ({64{ctrl.op_and}}  & (op1 & op2))
                 | ({64{ctrl.op_andn}} & (op1 & ~op2))
                 | ({64{ctrl.op_sll}}  & sh_out)
                 | ({64{ctrl.op_srl}}  & srl_res)
                 | ({64{ctrl.op_sra}}  & sra_res)
                 | ({64{ctrl.op_wri}}  & op1);

  assign res = ctrl.is_word ? {{32{raw_res[31]}}, raw_res[31:0]} : raw_res;

  assign flags = '{eq: eq, ne: ~eq, lt: lt, ge: ~lt, ltu: ltu, geu: ~ltu};

  // the reversed left shift must equal a plain right shift
  a_right_shift: assert #0 (!op_right || (srl_res == (sh_src >> sh_amt)))
    else $error("alu: right shift through the left shifter is wrong");

endmodule

`default_nettype wire

/* logic/rv_result.sv */
// Result stage: registers write-back, branch decision and next PC, one cycle
`timescale 1ns/1ps
`default_nettype none

module rv_result
  import rv_exec_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  dec_item_t   dec,
  input  logic [63:0] alu_res,
  input  bj_flags_t   flags,
  output wb_t         wb,
  output redirect_t   redir
);

  logic        cond;
  logic        taken_d;
  logic [63:0] base;
  logic [63:0] sum;
  logic [63:0] target_d;
  logic        valid_q;
  logic        wen_q;
  logic [4:0]  rd_q;
  logic [63:0] data_q;
  redirect_t   redir_q;

  // pick the flag named by the branch kind, jumps always go
  assign cond = (dec.br.beq  & flags.eq)
              | (dec.br.bne  & flags.ne)
              | (dec.br.blt  & flags.lt)
              | (dec.br.bge  & flags.ge)
              | (dec.br.bltu & flags.ltu)
              | (dec.br.bgeu & flags.geu)
              | dec.br.jal
              | dec.br.jalr;
  assign taken_d = dec.valid & ~dec.br.none & cond;

  assign base     = dec.br.jalr ? dec.rs1_val : dec.pc;
  assign sum      = base + dec.imm;
  // jalr target has bit 0 cleared
  assign target_d = taken_d ? {sum[63:1], sum[0] & ~dec.br.jalr} : 64'h0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      wen_q   <= 1'b0;
      redir_q <= '0;
    end else begin
      valid_q <= dec.valid;
      // x0 is never written
      wen_q   <= dec.valid & dec.wen & (dec.rd != 5'd0);
      redir_q <= '{taken: taken_d, target: target_d};
    end
  end

  always_ff @(posedge clk) begin
    rd_q   <= dec.rd;
    data_q <= alu_res;
  end

  assign wb    = '{valid: valid_q, rd: rd_q, wen: wen_q, data: data_q};
  assign redir = redir_q;

  // a valid item names exactly one branch kind, none included
  a_br_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    dec.valid |-> $onehot(dec.br))
    else $error("result: branch kind of a valid item is not one-hot");

endmodule

`default_nettype wire

/* logic/rv_exec_top.sv */
// Integer execute path: decode, ALU and result stage with a fixed two-cycle latency
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top
  import rv_exec_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        in_valid,
  input  instr_u      instr,
  input  logic [63:0] pc,
  input  logic [63:0] rs1_data,
  input  logic [63:0] rs2_data,
  output wb_t         wb,
  output redirect_t   redir
);

  dec_item_t   dec_q;
  logic [63:0] alu_res;
  bj_flags_t   flags;

  rv_decode u_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .instr    (instr),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec_q    (dec_q)
  );

  rv_alu u_alu (
    .ctrl  (dec_q.ctrl),
    .op1   (dec_q.op1),
    .op2   (dec_q.op2),
    .res   (alu_res),
    .flags (flags)
  );

  rv_result u_result (
    .clk     (clk),
    .arst_n  (arst_n),
    .dec     (dec_q),
    .alu_res (alu_res),
    .flags   (flags),
    .wb      (wb),
    .redir   (redir)
  );

  // every accepted instruction leaves exactly two edges later
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> ##2 wb.valid)
    else $error("top: result missing two cycles after issue");

endmodule

`default_nettype wire

/* tests/rv_exec_ref.svh */
// Execute path reference: expected write-back and redirect per instruction, typed compares
`ifndef RV_EXEC_REF_SVH
`define RV_EXEC_REF_SVH

typedef struct packed {
  wb_t       wb;
  redirect_t redir;
} exp_t;

function automatic exp_t exec_model(input logic [31:0] w, input logic [63:0] p,
                                    input logic [63:0] a, input logic [63:0] b);
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic        is_op;
  logic        alt;
  logic        cond;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] imm_b;
  logic [63:0] imm_j;
  logic [63:0] y;
  logic [31:0] a32;
  logic [31:0] r32;
  exp_t        e;
  opc   = w[6:0];
  f3    = w[14:12];
  alt   = w[30];
  is_op = (opc == OPC_OP) || (opc == OPC_OP_32);
  imm_i = {{52{w[31]}}, w[31:20]};
  imm_u = {{32{w[31]}}, w[31:12], 12'h000};
  imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  y     = is_op ? b : imm_i;
  a32   = a[31:0];
  cond  = 1'b0;
  e          = '0;
  e.wb.valid = 1'b1;
  e.wb.rd    = w[11:7];
  case (opc)
    OPC_OP, OPC_OP_IMM: begin
      e.wb.wen = 1'b1;
      case (f3)
        3'd0: e.wb.data = (is_op && alt) ? a - y : a + y;
        3'd1: e.wb.data = a << y[5:0];
        3'd2: e.wb.data = {63'h0, $signed(a) < $signed(y)};
        3'd3: e.wb.data = {63'h0, a < y};
        3'd4: e.wb.data = a ^ y;
        3'd5: begin
          if (alt)
            e.wb.data = $signed(a) >>> y[5:0];
          else
            e.wb.data = a >> y[5:0];
        end
        3'd6: e.wb.data = a | y;
        default: e.wb.data = (is_op && alt) ? a & ~y : a & y;
      endcase
    end
    OPC_OP_32, OPC_OP_IMM_32: begin
      // only addw, subw and the word shifts exist
      e.wb.wen = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5);
      r32 = 32'h0;
      if (f3 == 3'd0) r32 = (is_op && alt) ? a32 - y[31:0] : a32 + y[31:0];
      if (f3 == 3'd1) r32 = a32 << y[4:0];
      if (f3 == 3'd5) begin
        if (alt)
          r32 = $signed(a32) >>> y[4:0];
        else
          r32 = a32 >> y[4:0];
      end
      e.wb.data = {{32{r32[31]}}, r32};
    end
    OPC_LUI: begin
      e.wb.wen  = 1'b1;
      e.wb.data = imm_u;
    end
    OPC_AUIPC: begin
      e.wb.wen  = 1'b1;
      e.wb.data = p + imm_u;
    end
    OPC_JAL: begin
      e.wb.wen     = 1'b1;
      e.wb.data    = p + 64'd4;
      e.redir.taken  = 1'b1;
      e.redir.target = p + imm_j;
    end
    OPC_JALR: begin
      e.wb.wen     = 1'b1;
      e.wb.data    = p + 64'd4;
      e.redir.taken  = 1'b1;
      e.redir.target = (a + imm_i) & ~64'd1;
    end
    OPC_BRANCH: begin
      e.wb.data = a - b;
      case (f3)
        3'd0: cond = (a == b);
        3'd1: cond = (a != b);
        3'd4: cond = $signed(a) < $signed(b);
        3'd5: cond = $signed(a) >= $signed(b);
        3'd6: cond = a < b;
        3'd7: cond = a >= b;
        default: cond = 1'b0;
      endcase
      e.redir.taken  = cond;
      e.redir.target = cond ? p + imm_b : 64'h0;
    end
    default: ;
  endcase
  if (e.wb.rd == 5'd0) e.wb.wen = 1'b0;
  return e;
endfunction

task automatic check_wb(input wb_t exp, input wb_t act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("[ERROR] %0t wb: expected v=%b rd=%0d wen=%b data=%h, got v=%b rd=%0d wen=%b data=%h",
             $time, exp.valid, exp.rd, exp.wen, exp.data, act.valid, act.rd, act.wen, act.data);
  end
endtask

task automatic check_redir(input redirect_t exp, input redirect_t act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("[ERROR] %0t redir: expected taken=%b target=%h, got taken=%b target=%h",
             $time, exp.taken, exp.target, act.taken, act.target);
  end
endtask

`endif

/* tests/rv_exec_tb.sv */
// Execute path testbench: directed and random instructions checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb
  import rv_exec_pkg::*;
();

  logic        clk;
  logic        arst_n;
  logic        in_valid;
  instr_u      instr;
  logic [63:0] pc;
  logic [63:0] rs1_data;
  logic [63:0] rs2_data;
  wb_t         wb;
  redirect_t   redir;
  integer      seed;
  int          errors;
  int          checks;
  int          tests;
  int          ncyc;
  int          due_q[$];

  `include "rv_exec_ref.svh"

  exp_t exp_q[$];

  rv_exec_top UUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .instr    (instr),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb),
    .redir    (redir)
  );

  always #5 clk = ~clk;

  function automatic logic [63:0] edge_val(input int k);
    case (k % 8)
      0: return 64'h0;
      1: return 64'h1;
      2: return '1;
      3: return 64'h8000_0000_0000_0000;
      4: return 64'h7fff_ffff_ffff_ffff;
      5: return 64'h0000_0000_8000_0000;
      6: return 64'h0000_0000_7fff_ffff;
      default: return 64'h0000_0000_ffff_ffff;
    endcase
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {imm, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] i, input logic [2:0] f3);
    return {i[12], i[10:5], 5'd2, 5'd1, f3, i[4:1], i[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] i, input logic [4:0] rd);
    return {i[20], i[10:1], i[11], i[19:12], rd, OPC_JAL};
  endfunction

  task automatic rand_val(output logic [63:0] v);
    logic [31:0] r;
    r = $random(seed);
    if (r[1:0] == 2'd0) v = edge_val(r[7:4]);
    else v = {$random(seed), $random(seed)};
  endtask

  task automatic issue(input logic [31:0] w, input logic [63:0] p,
                       input logic [63:0] a, input logic [63:0] b);
    @(posedge clk);
    in_valid <= 1'b1;
    instr    <= w;
    pc       <= p;
    rs1_data <= a;
    rs2_data <= b;
    exp_q.push_back(exec_model(w, p, a, b));
    // result shows at the third falling edge after this drive
    due_q.push_back(ncyc + 3);
  endtask

  task automatic finish_test(input string name, input int err0);
    int waited;
    waited = 0;
    @(posedge clk);
    in_valid <= 1'b0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d results never arrived", name, exp_q.size());
      errors++;
      exp_q.delete();
      due_q.delete();
    end
    tests++;
    $display("test %s %s, %0d errors", name, (errors == err0) ? "ok" : "bad", errors - err0);
  endtask

  task automatic arith_ops();
    int e0;
    logic [63:0] a;
    logic [63:0] b;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 8; j++) begin
        a = edge_val(i);
        b = edge_val(j);
        for (int f = 0; f < 8; f++) begin
          issue(r_word(7'h00, f[2:0], 5'd5, OPC_OP), 64'h100, a, b);
          issue(i_word(b[11:0], f[2:0], 5'd6, OPC_OP_IMM), 64'h104, a, b);
        end
        issue(r_word(7'h20, 3'd0, 5'd7, OPC_OP), 64'h108, a, b);
        issue(r_word(7'h20, 3'd7, 5'd8, OPC_OP), 64'h10c, a, b);
      end
    end
    finish_test("arith", e0);
  endtask

  task automatic shift_ops();
    int e0;
    int amts[5] = '{0, 1, 31, 32, 63};
    logic [5:0] s;
    logic [63:0] a;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      a = (i == 0) ? 64'h8123_4567_89ab_cdef : edge_val(i);
      foreach (amts[k]) begin
        s = amts[k][5:0];
        issue(i_word({6'h00, s}, 3'd1, 5'd3, OPC_OP_IMM), 64'h200, a, 64'h0);
        issue(i_word({6'h00, s}, 3'd5, 5'd3, OPC_OP_IMM), 64'h200, a, 64'h0);
        issue(i_word({6'h10, s}, 3'd5, 5'd3, OPC_OP_IMM), 64'h200, a, 64'h0);
        issue(r_word(7'h00, 3'd1, 5'd4, OPC_OP), 64'h204, a, {58'h0, s});
        issue(r_word(7'h00, 3'd5, 5'd4, OPC_OP), 64'h204, a, {58'h0, s});
        issue(r_word(7'h20, 3'd5, 5'd4, OPC_OP), 64'h204, a, {58'h0, s});
        // word forms take amounts up to 31
        issue(i_word({7'h00, s[4:0]}, 3'd1, 5'd9, OPC_OP_IMM_32), 64'h208, a, 64'h0);
        issue(i_word({7'h20, s[4:0]}, 3'd5, 5'd9, OPC_OP_IMM_32), 64'h208, a, 64'h0);
        issue(r_word(7'h00, 3'd5, 5'd9, OPC_OP_32), 64'h20c, a, {58'h0, s});
        issue(r_word(7'h20, 3'd0, 5'd9, OPC_OP_32), 64'h20c, a, edge_val(k + 3));
      end
    end
    finish_test("shifts", e0);
  endtask

  task automatic upper_and_jumps();
    int e0;
    logic [63:0] p;
    logic [63:0] a;
    logic [31:0] r;
    e0 = errors;
    for (int i = 0; i < 60; i++) begin
      r = $random(seed);
      rand_val(a);
      p = {$random(seed), $random(seed)} & ~64'd3;
      issue({r[31:12], 5'd10, OPC_LUI}, p, a, 64'h0);
      issue({r[31:12], 5'd11, OPC_AUIPC}, p, a, 64'h0);
      issue(j_word({r[20:1], 1'b0}, 5'd1), p, a, 64'h0);
      // odd base makes bit 0 of the jalr target matter
      issue(i_word(r[11:0], 3'd0, 5'd1, OPC_JALR), p, a | 64'd1, 64'h0);
    end
    finish_test("upper_jump", e0);
  endtask

  task automatic branch_pairs();
    int e0;
    int f3s[6] = '{0, 1, 4, 5, 6, 7};
    logic [63:0] a;
    logic [63:0] b;
    e0 = errors;
    foreach (f3s[k]) begin
      for (int i = 0; i < 8; i++) begin
        for (int j = 0; j < 8; j++) begin
          a = edge_val(i);
          b = edge_val(j);
          issue(b_word(13'h1ff0 + 13'(i * 8), f3s[k][2:0]), 64'h4000 + 64'(j * 4), a, b);
        end
      end
    end
    finish_test("branches", e0);
  endtask

  task automatic corner_cases();
    int e0;
    e0 = errors;
    issue(r_word(7'h00, 3'd0, 5'd0, OPC_OP), 64'h300, 64'd5, 64'd6);
    issue(i_word(12'h7ff, 3'd0, 5'd0, OPC_OP_IMM), 64'h300, 64'd5, 64'd6);
    issue(j_word(21'h000010, 5'd0), 64'h300, 64'd5, 64'd6);
    issue(i_word(12'h123, 3'd2, 5'd12, 7'b0000011), 64'h304, 64'd1, 64'd1);
    issue(i_word(12'h123, 3'd0, 5'd12, 7'b1111111), 64'h304, 64'd1, 64'd1);
    issue(r_word(7'h00, 3'd2, 5'd13, OPC_OP_32), 64'h308, 64'd3, 64'd9);
    issue(b_word(13'h0040, 3'd2), 64'h30c, 64'd3, 64'd3);
    finish_test("corner", e0);
  endtask

  task automatic random_stream();
    int e0;
    logic [6:0] opcs[9] = '{OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32, OPC_LUI,
                            OPC_AUIPC, OPC_BRANCH, OPC_JAL, OPC_JALR};
    logic [31:0] w;
    logic [31:0] k;
    logic [63:0] a;
    logic [63:0] b;
    e0 = errors;
    for (int n = 0; n < 2000; n++) begin
      w = $random(seed);
      k = $random(seed);
      k = k % 10;
      if (k < 9) w[6:0] = opcs[k];
      if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_32) w[31:25] = {1'b0, w[30], 5'h00};
      rand_val(a);
      rand_val(b);
      issue(w, {$random(seed), $random(seed)}, a, b);
    end
    finish_test("stream", e0);
  endtask

  // compares every falling edge, also catches results that nobody issued
  initial begin
    exp_t e;
    int   d;
    forever begin
      @(negedge clk);
      ncyc++;
      if (wb.valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("a result appeared at %0t with nothing issued", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          d = due_q.pop_front();
          if (ncyc != d) begin
            $display("result at %0t arrived %0d cycles off its slot", $time, ncyc - d);
            errors++;
          end
          check_wb(e.wb, wb);
          check_redir(e.redir, redir);
        end
      end else begin
        if (redir.taken !== 1'b0) begin
          $display("redirect taken at %0t without a valid result", $time);
          errors++;
        end
        if (wb.valid !== 1'b0) begin
          $display("wb.valid is unknown at %0t", $time);
          errors++;
        end
        if (exp_q.size() != 0 && ncyc > due_q[0]) begin
          $display("result missing two cycles after issue, seen at %0t", $time);
          errors++;
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end
    end
  end

  initial begin
    int c;
    c = 0;
    while (c < 100000) begin
      @(posedge clk);
      c++;
    end
    $display("simulation ran out of time");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int e0;
    seed     = 84;
    clk      = 1'b0;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    instr    = '0;
    pc       = '0;
    rs1_data = '0;
    rs2_data = '0;
    e0       = errors;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    // idle cycles after reset must stay quiet
    repeat (3) @(posedge clk);
    finish_test("reset", e0);
    arith_ops();
    shift_ops();
    upper_and_jumps();
    branch_pairs();
    corner_cases();
    random_stream();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv_exec.f */
+incdir+tests
logic/rv_exec_pkg.sv
logic/rv_decode.sv
logic/rv_alu.sv
logic/rv_result.sv
logic/rv_exec_top.sv
tests/rv_exec_tb.sv

/* Bender.yml */
package:
  name: rv_exec

sources:
  - logic/rv_exec_pkg.sv
  - logic/rv_decode.sv
  - logic/rv_alu.sv
  - logic/rv_result.sv
  - logic/rv_exec_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/rv_exec_tb.sv
